//--- common/bp_pkg.sv
`default_nettype none

package bp_pkg;

    // Address and block geometry
    localparam int VADDR_W     = 32;
    localparam int INST_OFFSET = 2;
    localparam int BLOCK_W     = 3;
    localparam int SLOT_NUM    = 2;

    // Default BTB geometry, overridden from the top level
    localparam int BTB_SETS_W = 6;
    localparam int TAG_W      = 10;

    // Low target bits kept per slot
    localparam int TARGET_W = 12;

    localparam logic [VADDR_W-1:0] RESET_PC = 32'h8000_0000;

    typedef enum logic [1:0] {
        COND     = 2'd0,
        DIRECT   = 2'd1,
        INDIRECT = 2'd2
    } br_type_e;

    // High part of a target relative to the fetch PC
    typedef enum logic [1:0] {
        TAR_NONE = 2'd0,
        TAR_OV   = 2'd1,
        TAR_UN   = 2'd2
    } tar_state_e;

    typedef struct packed {
        logic                en;
        logic [BLOCK_W-1:0]  offset;
        logic [TARGET_W-1:0] target;
        tar_state_e          tar_state;
        br_type_e            br_type;
    } slot_t;

    typedef struct packed {
        logic               en;
        logic [TAG_W-1:0]   tag;
        slot_t              cond;
        slot_t              tail;
        logic [BLOCK_W-1:0] fth_addr;
    } btb_entry_t;

    typedef struct packed {
        logic                en;
        logic                hit;
        logic [VADDR_W-1:0]  start;
        logic [VADDR_W-1:0]  target;
        logic                taken;
        logic                tail_taken;
        logic [SLOT_NUM-1:0] pred_taken;
        btb_entry_t          entry;
    } pred_result_t;

    typedef struct packed {
        logic [VADDR_W-1:0]  pc;
        btb_entry_t          entry;
        logic [SLOT_NUM-1:0] taken;
    } update_t;

endpackage

`default_nettype wire

//--- btb/btb_table.sv
`timescale 1ns/1ns
`default_nettype none

module btb_table #(
    parameter int BTB_SETS_W = bp_pkg::BTB_SETS_W,
    parameter int TAG_W      = bp_pkg::TAG_W
) (
    input  wire logic                       clk,
    input  wire logic                       rst_n_i,
    input  wire logic [bp_pkg::VADDR_W-1:0] lookup_pc_i,
    input  wire logic                       update_i,
    input  wire bp_pkg::update_t            update_info_i,
    output bp_pkg::btb_entry_t              entry_o,
    output logic                            hit_o
);

    localparam int SETS   = 1 << BTB_SETS_W;
    localparam int IDX_LO = bp_pkg::INST_OFFSET + bp_pkg::BLOCK_W;
    localparam int TAG_LO = IDX_LO + BTB_SETS_W;

    bp_pkg::btb_entry_t    entry_mem [SETS];
    logic [SETS-1:0]       valid_q;

    logic [BTB_SETS_W-1:0] rd_idx;
    logic [BTB_SETS_W-1:0] wr_idx;
    logic [TAG_W-1:0]      rd_tag;
    logic [TAG_W-1:0]      wr_tag;
    bp_pkg::btb_entry_t    wr_entry;

    bp_pkg::btb_entry_t    rd_entry_q;
    logic [TAG_W-1:0]      lookup_tag_q;
    logic                  rd_valid_q;

    assign rd_idx = lookup_pc_i[IDX_LO +: BTB_SETS_W];
    assign rd_tag = lookup_pc_i[TAG_LO +: TAG_W];
    assign wr_idx = update_info_i.pc[IDX_LO +: BTB_SETS_W];
    assign wr_tag = update_info_i.pc[TAG_LO +: TAG_W];

    // Stored tag always comes from the update PC
    always_comb begin
        wr_entry     = update_info_i.entry;
        wr_entry.tag = bp_pkg::TAG_W'(wr_tag);
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (update_i) begin
            valid_q[wr_idx] <= update_info_i.entry.en;
        end
    end

    always_ff @(posedge clk) begin
        if (update_i) begin
            entry_mem[wr_idx] <= wr_entry;
        end
        rd_entry_q <= entry_mem[rd_idx];
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_valid_q   <= 1'b0;
            lookup_tag_q <= '0;
        end else begin
            rd_valid_q   <= valid_q[rd_idx];
            lookup_tag_q <= rd_tag;
        end
    end

    assign hit_o = rd_valid_q && (rd_entry_q.tag == bp_pkg::TAG_W'(lookup_tag_q));

    always_comb begin
        entry_o    = rd_entry_q;
        entry_o.en = rd_valid_q;
    end

    // Valid array and stored entry must agree on a hit
    a_hit_valid : assert property (@(posedge clk) disable iff (!rst_n_i)
        hit_o |-> rd_entry_q.en);

endmodule

`default_nettype wire

//--- verilog/dir_counter_table.sv
`timescale 1ns/1ns
`default_nettype none

module dir_counter_table #(
    parameter int BTB_SETS_W = bp_pkg::BTB_SETS_W
) (
    input  wire logic                        clk,
    input  wire logic                        rst_n_i,
    input  wire logic [bp_pkg::VADDR_W-1:0]  lookup_pc_i,
    input  wire logic                        update_i,
    input  wire bp_pkg::update_t             update_info_i,
    output logic [bp_pkg::SLOT_NUM-1:0]      dir_o
);

    localparam int SETS   = 1 << BTB_SETS_W;
    localparam int IDX_LO = bp_pkg::INST_OFFSET + bp_pkg::BLOCK_W;

    logic [1:0]                  ctr_q [SETS][bp_pkg::SLOT_NUM];
    logic [1:0]                  rd_ctr_q [bp_pkg::SLOT_NUM];
    logic [BTB_SETS_W-1:0]       rd_idx;
    logic [BTB_SETS_W-1:0]       wr_idx;
    logic [bp_pkg::SLOT_NUM-1:0] slot_en;

    assign rd_idx  = lookup_pc_i[IDX_LO +: BTB_SETS_W];
    assign wr_idx  = update_info_i.pc[IDX_LO +: BTB_SETS_W];
    assign slot_en = {update_info_i.entry.tail.en, update_info_i.entry.cond.en};

    function automatic logic [1:0] sat_step(input logic [1:0] ctr, input logic taken);
        logic [1:0] nxt;
        nxt = ctr;
        if (taken && ctr != 2'b11) begin
            nxt = ctr + 2'd1;
        end else if (!taken && ctr != 2'b00) begin
            nxt = ctr - 2'd1;
        end
        return nxt;
    endfunction

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            // Weakly not taken
            for (int s = 0; s < SETS; s++) begin
                for (int k = 0; k < bp_pkg::SLOT_NUM; k++) begin
                    ctr_q[s][k] <= 2'b01;
                end
            end
            for (int k = 0; k < bp_pkg::SLOT_NUM; k++) begin
                rd_ctr_q[k] <= 2'b01;
            end
        end else begin
            for (int k = 0; k < bp_pkg::SLOT_NUM; k++) begin
                rd_ctr_q[k] <= ctr_q[rd_idx][k];
                if (update_i && slot_en[k]) begin
                    ctr_q[wr_idx][k] <= sat_step(ctr_q[wr_idx][k], update_info_i.taken[k]);
                end
            end
        end
    end

    always_comb begin
        for (int k = 0; k < bp_pkg::SLOT_NUM; k++) begin
            dir_o[k] = rd_ctr_q[k][1];
        end
    end

endmodule

`default_nettype wire

//--- verilog/pred_result_gen.sv
`timescale 1ns/1ns
`default_nettype none

module pred_result_gen #(
    parameter bit USE_BTB_READ = 1'b1,
    parameter bit USE_IND      = 1'b0
) (
    input  wire bp_pkg::pred_result_t        result_i,
    input  wire bp_pkg::btb_entry_t          entry_i,
    input  wire logic                        btb_hit_i,
    input  wire logic [bp_pkg::SLOT_NUM-1:0] dir_i,
    input  wire logic [bp_pkg::VADDR_W-1:0]  ind_target_i,
    output bp_pkg::pred_result_t             result_o,
    output logic                             redirect_o
);

    localparam int VADDR_W = bp_pkg::VADDR_W;
    localparam int HIGH_W  = VADDR_W - bp_pkg::TARGET_W - bp_pkg::INST_OFFSET;

    logic                        hit;
    bp_pkg::btb_entry_t          entry;
    bp_pkg::btb_entry_t          entry_out;
    logic [VADDR_W-1:0]          pc;

    logic [bp_pkg::SLOT_NUM-1:0] br_taken;
    logic [bp_pkg::SLOT_NUM-1:0] pred_taken;
    logic                        older;
    logic                        any_br;
    logic                        tail_taken;
    logic [VADDR_W-1:0]          br_target;
    logic [VADDR_W-1:0]          tail_target;
    logic [VADDR_W-1:0]          fth_target;
    logic [VADDR_W-1:0]          predict_pc;
    logic [bp_pkg::BLOCK_W:0]    fth_off;

    // PC high part, adjusted by the target state, then low target bits
    function automatic logic [VADDR_W-1:0] build_target(
        input logic [VADDR_W-1:0] base,
        input bp_pkg::slot_t      slot
    );
        logic [HIGH_W-1:0] high;
        high = base[VADDR_W-1 -: HIGH_W];
        case (slot.tar_state)
            bp_pkg::TAR_OV: high = high + 1'b1;
            bp_pkg::TAR_UN: high = high - 1'b1;
            default:        high = high;
        endcase
        return {high, slot.target, {bp_pkg::INST_OFFSET{1'b0}}};
    endfunction

    generate
        if (USE_BTB_READ) begin : g_btb_read
            assign hit       = btb_hit_i | result_i.hit;
            assign entry     = btb_hit_i ? entry_i : result_i.entry;
            assign entry_out = hit ? entry : '0;
        end else begin : g_carried
            assign hit       = result_i.hit;
            assign entry     = result_i.entry;
            assign entry_out = result_i.entry;
        end
    endgenerate

    assign pc = result_i.start;

    assign br_taken[0] = entry.cond.en & dir_i[0];
    assign br_taken[1] = entry.tail.en & (entry.tail.br_type == bp_pkg::COND) & dir_i[1];

    // Lower offset wins when both slots are taken
    assign older         = entry.cond.offset < entry.tail.offset;
    assign pred_taken[0] = br_taken[0] & (older | ~br_taken[1]);
    assign pred_taken[1] = br_taken[1] & (~older | ~br_taken[0]);
    assign any_br        = |pred_taken;

    assign br_target = pred_taken[0] ? build_target(pc, entry.cond)
                                     : build_target(pc, entry.tail);

    assign tail_taken = entry.tail.en & (entry.tail.br_type != bp_pkg::COND);

    always_comb begin
        if (USE_IND && entry.tail.br_type == bp_pkg::INDIRECT) begin
            tail_target = ind_target_i;
        end else begin
            tail_target = build_target(pc, entry.tail);
        end
    end

    assign fth_off    = (bp_pkg::BLOCK_W + 1)'(entry.fth_addr) + 1'b1;
    assign fth_target = pc + VADDR_W'({fth_off, {bp_pkg::INST_OFFSET{1'b0}}});

    assign predict_pc = any_br     ? br_target   :
                        tail_taken ? tail_target : fth_target;

    always_comb begin
        result_o            = result_i;
        result_o.hit        = hit;
        result_o.target     = hit ? predict_pc : result_i.target;
        result_o.taken      = hit & (any_br | tail_taken);
        result_o.tail_taken = hit & ~any_br & tail_taken;
        result_o.pred_taken = hit ? pred_taken : '0;
        result_o.entry      = entry_out;
    end

    assign redirect_o = result_i.en & hit &
                        ((pred_taken != result_i.pred_taken) |
                         (~any_br & tail_taken & (tail_target != result_i.target)));

    always_comb begin
        a_one_taken : assert #0 ($onehot0(result_o.pred_taken));
    end

endmodule

`default_nettype wire

//--- verilog/fetch_predictor.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_predictor #(
    parameter int BTB_SETS_W = bp_pkg::BTB_SETS_W,
    parameter int TAG_W      = bp_pkg::TAG_W
) (
    input  wire logic                       clk,
    input  wire logic                       rst_n_i,
    input  wire logic                       stall_i,
    input  wire logic                       squash_i,
    input  wire logic [bp_pkg::VADDR_W-1:0] squash_target_i,
    input  wire logic                       update_i,
    input  wire bp_pkg::update_t            update_info_i,
    input  wire logic [bp_pkg::VADDR_W-1:0] ind_target_i,
    output logic                            pred_valid_o,
    output bp_pkg::pred_result_t            pred_o,
    output logic                            redirect_o,
    output logic                            last_stage_o,
    output bp_pkg::pred_result_t            last_pred_o
);

    localparam int BLOCK_BYTES = 1 << (bp_pkg::BLOCK_W + bp_pkg::INST_OFFSET);

    logic [bp_pkg::VADDR_W-1:0]  pc;
    bp_pkg::pred_result_t        s1_result;
    bp_pkg::pred_result_t        s2_q;
    bp_pkg::pred_result_t        s3_q;
    bp_pkg::pred_result_t        s2_result;
    bp_pkg::pred_result_t        s3_result;
    bp_pkg::btb_entry_t          btb_entry;
    logic                        btb_hit;
    logic [bp_pkg::SLOT_NUM-1:0] dir_s2;
    logic [bp_pkg::SLOT_NUM-1:0] dir_s3_q;
    logic                        s2_redirect;
    logic                        s3_redirect;

    // Stage 1 always predicts a full fall-through block
    always_comb begin
        s1_result        = '0;
        s1_result.en     = ~stall_i;
        s1_result.start  = pc;
        s1_result.target = pc + BLOCK_BYTES;
    end

    btb_table #(
        .BTB_SETS_W (BTB_SETS_W),
        .TAG_W      (TAG_W)
    ) u_btb (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .lookup_pc_i   (pc),
        .update_i      (update_i),
        .update_info_i (update_info_i),
        .entry_o       (btb_entry),
        .hit_o         (btb_hit)
    );

    dir_counter_table #(
        .BTB_SETS_W (BTB_SETS_W)
    ) u_dir (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .lookup_pc_i   (pc),
        .update_i      (update_i),
        .update_info_i (update_info_i),
        .dir_o         (dir_s2)
    );

    pred_result_gen #(
        .USE_BTB_READ (1'b1),
        .USE_IND      (1'b0)
    ) u_s2_gen (
        .result_i     (s2_q),
        .entry_i      (btb_entry),
        .btb_hit_i    (btb_hit),
        .dir_i        (dir_s2),
        .ind_target_i (ind_target_i),
        .result_o     (s2_result),
        .redirect_o   (s2_redirect)
    );

    pred_result_gen #(
        .USE_BTB_READ (1'b0),
        .USE_IND      (1'b1)
    ) u_s3_gen (
        .result_i     (s3_q),
        .entry_i      (s3_q.entry),
        .btb_hit_i    (1'b0),
        .dir_i        (dir_s3_q),
        .ind_target_i (ind_target_i),
        .result_o     (s3_result),
        .redirect_o   (s3_redirect)
    );

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc <= bp_pkg::RESET_PC;
        end else if (squash_i) begin
            pc <= squash_target_i;
        end else if (s3_redirect) begin
            pc <= s3_result.target;
        end else if (s2_redirect) begin
            pc <= s2_result.target;
        end else if (!stall_i) begin
            pc <= s1_result.target;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s2_q <= '0;
            s3_q <= '0;
        end else begin
            if (squash_i || s2_redirect || s3_redirect) begin
                s2_q.en <= 1'b0;
            end else begin
                s2_q <= s1_result;
            end
            if (squash_i || s3_redirect) begin
                s3_q.en <= 1'b0;
            end else begin
                s3_q <= s2_result;
            end
        end
    end

    always_ff @(posedge clk) begin
        dir_s3_q <= dir_s2;
    end

    assign pred_o = s3_redirect ? s3_result :
                    s2_redirect ? s2_result : s1_result;

    assign pred_valid_o = pred_o.en & ~squash_i;
    assign redirect_o   = (s2_redirect | s3_redirect) & ~squash_i;
    assign last_stage_o = s3_result.en & ~squash_i;
    assign last_pred_o  = s3_result;

endmodule

`default_nettype wire

//--- verif/tb_fetch_predictor_tasks.svh
`ifndef TB_FETCH_PREDICTOR_TASKS_SVH
`define TB_FETCH_PREDICTOR_TASKS_SVH

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
endfunction

function automatic logic [31:0] rand_block();
    return lcg_next() & 32'hFFFF_FFE0;
endfunction

function automatic logic [11:0] rand_low();
    logic [31:0] r;
    r = lcg_next();
    return r[31:20];
endfunction

// High part above the 12 low target bits and the two byte bits
function automatic logic [31:0] expected_target(input logic [31:0] pc, input logic [11:0] low,
        input bp_pkg::tar_state_e st);
    logic [31:0] high;
    high = pc >> 14;
    case (st)
        bp_pkg::TAR_OV: high = high + 32'd1;
        bp_pkg::TAR_UN: high = high - 32'd1;
        default:        high = high;
    endcase
    return (high << 14) | ({20'd0, low} << 2);
endfunction

function automatic bp_pkg::btb_entry_t make_entry(input logic [31:0] pc, input logic is_ind,
        input logic [11:0] low, input bp_pkg::tar_state_e st);
    bp_pkg::btb_entry_t e;
    e          = '0;
    e.en       = 1'b1;
    e.tag      = pc[TAG_LO +: TAG_BITS];
    e.fth_addr = 3'd7;
    if (is_ind) begin
        e.tail = '{en: 1'b1, offset: 3'd5, target: low, tar_state: st,
                   br_type: bp_pkg::INDIRECT};
    end else begin
        e.cond = '{en: 1'b1, offset: 3'd2, target: low, tar_state: st,
                   br_type: bp_pkg::COND};
    end
    return e;
endfunction

function automatic bp_pkg::pred_result_t hit_result(input logic [31:0] start,
        input logic [31:0] target, input logic tail_taken, input logic [1:0] pred_taken,
        input bp_pkg::btb_entry_t e);
    return '{en: 1'b1, hit: 1'b1, start: start, target: target, taken: 1'b1,
             tail_taken: tail_taken, pred_taken: pred_taken, entry: e};
endfunction

task automatic tick();
    @(posedge clk);
    #1;
endtask

task automatic write_entry(input logic [31:0] pc, input bp_pkg::btb_entry_t e,
        input logic [1:0] taken);
    update_i      = 1'b1;
    update_info_i = '{pc: pc, entry: e, taken: taken};
    tick();
    update_i = 1'b0;
endtask

task automatic squash_to(input logic [31:0] addr);
    squash_i        = 1'b1;
    squash_target_i = addr;
    tick();
    squash_i = 1'b0;
endtask

task automatic compare_result(input string name, input bp_pkg::pred_result_t got,
        input bp_pkg::pred_result_t exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
endtask

task automatic compare_addr(input string name, input logic [bp_pkg::VADDR_W-1:0] got,
        input logic [bp_pkg::VADDR_W-1:0] exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
endtask

task automatic compare_strobe(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
endtask

task automatic end_test(input string name, input int errs_before);
    $display("%s finished with %0d errors", name, error_count - errs_before);
endtask

// Trains a cond entry, squashes to it and returns in the cycle after issue
task automatic issue_cond_block(input bp_pkg::tar_state_e st, output logic [31:0] pc,
        output logic [31:0] tgt, output bp_pkg::btb_entry_t e);
    logic [11:0] low;
    pc  = rand_block();
    low = rand_low();
    e   = make_entry(pc, 1'b0, low, st);
    tgt = expected_target(pc, low, st);
    write_entry(pc, e, 2'b01);
    write_entry(pc, e, 2'b01);
    squash_to(pc);
    #2;
    compare_addr("pred_o.start", pred_o.start, pc);
    tick();
endtask

task automatic cond_redirect_case(input bp_pkg::tar_state_e st);
    logic [31:0]        pc;
    logic [31:0]        tgt;
    bp_pkg::btb_entry_t e;
    issue_cond_block(st, pc, tgt, e);
    #2;
    compare_strobe("redirect_o", redirect_o, 1'b1);
    compare_result("pred_o", pred_o, hit_result(pc, tgt, 1'b0, 2'b01, e));
    tick();
    #2;
    compare_addr("pred_o.start", pred_o.start, tgt);
    compare_strobe("redirect_o", redirect_o, 1'b0);
    tick();
    write_entry(pc, '0, 2'b00);
endtask

task automatic fall_through_after_reset();
    int          errs;
    logic [31:0] start;
    errs = error_count;
    for (int i = 0; i < 6; i++) begin
        start = bp_pkg::RESET_PC + BLOCK_BYTES * i;
        #2;
        if (i == 0) begin
            compare_strobe("last_stage_o", last_stage_o, 1'b0);
        end
        compare_addr("pred_o.start", pred_o.start, start);
        compare_addr("pred_o.target", pred_o.target, start + BLOCK_BYTES);
        compare_strobe("redirect_o", redirect_o, 1'b0);
        tick();
    end
    end_test("fall_through_after_reset", errs);
endtask

task automatic cond_branch_redirect();
    int errs;
    errs = error_count;
    cond_redirect_case(bp_pkg::TAR_NONE);
    end_test("cond_branch_redirect", errs);
endtask

task automatic target_state_wrap();
    int errs;
    errs = error_count;
    cond_redirect_case(bp_pkg::TAR_OV);
    cond_redirect_case(bp_pkg::TAR_UN);
    end_test("target_state_wrap", errs);
endtask

// Pass 0 uses a random indirect target, pass 1 repeats the stage-2 target
task automatic indirect_tail_target();
    int                 errs;
    logic [31:0]        pc;
    logic [31:0]        tgt;
    logic [11:0]        low;
    bp_pkg::btb_entry_t e;
    errs = error_count;
    for (int pass = 0; pass < 2; pass++) begin
        pc  = rand_block();
        low = rand_low();
        tgt = expected_target(pc, low, bp_pkg::TAR_NONE);
        if (tgt == pc + BLOCK_BYTES) begin
            low = low ^ 12'h001;
            tgt = tgt ^ 32'h0000_0004;
        end
        e            = make_entry(pc, 1'b1, low, bp_pkg::TAR_NONE);
        ind_target_i = (pass == 0) ? (lcg_next() & 32'hFFFF_FFFC) : tgt;
        write_entry(pc, e, 2'b10);
        squash_to(pc);
        tick();
        #2;
        compare_strobe("redirect_o", redirect_o, 1'b1);
        compare_addr("pred_o.target", pred_o.target, tgt);
        tick();
        #2;
        compare_strobe("last_stage_o", last_stage_o, 1'b1);
        compare_result("last_pred_o", last_pred_o, hit_result(pc, ind_target_i, 1'b1, 2'b00, e));
        compare_strobe("redirect_o", redirect_o, ind_target_i != tgt);
        tick();
        #2;
        compare_addr("pred_o.start", pred_o.start,
                     (ind_target_i != tgt) ? ind_target_i : tgt + BLOCK_BYTES);
        tick();
        write_entry(pc, '0, 2'b00);
    end
    ind_target_i = '0;
    end_test("indirect_tail_target", errs);
endtask

task automatic squash_over_redirect();
    int                 errs;
    logic [31:0]        pc;
    logic [31:0]        tgt;
    logic [31:0]        sq;
    bp_pkg::btb_entry_t e;
    errs = error_count;
    issue_cond_block(bp_pkg::TAR_NONE, pc, tgt, e);
    sq              = rand_block();
    squash_i        = 1'b1;
    squash_target_i = sq;
    #2;
    compare_strobe("redirect_o", redirect_o, 1'b0);
    compare_strobe("pred_valid_o", pred_valid_o, 1'b0);
    tick();
    squash_i = 1'b0;
    #2;
    compare_addr("pred_o.start", pred_o.start, sq);
    compare_strobe("redirect_o", redirect_o, 1'b0);
    tick();
    write_entry(pc, '0, 2'b00);
    end_test("squash_over_redirect", errs);
endtask

task automatic stall_holds_pc();
    int          errs;
    logic [31:0] pc;
    errs = error_count;
    pc   = rand_block();
    squash_to(pc);
    stall_i = 1'b1;
    repeat (3) begin
        #2;
        compare_addr("pred_o.start", pred_o.start, pc);
        compare_strobe("pred_valid_o", pred_valid_o, 1'b0);
        tick();
    end
    stall_i = 1'b0;
    for (int i = 0; i < 3; i++) begin
        #2;
        compare_addr("pred_o.start", pred_o.start, pc + BLOCK_BYTES * i);
        compare_strobe("pred_valid_o", pred_valid_o, 1'b1);
        tick();
    end
    end_test("stall_holds_pc", errs);
endtask

`endif

//--- verif/tb_fetch_predictor.sv
`timescale 1ns/1ns
`default_nettype none

module tb_fetch_predictor;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 5;
    localparam int SETS_W       = 6;
    localparam int TAG_BITS     = 10;
    localparam int TAG_LO       = bp_pkg::INST_OFFSET + bp_pkg::BLOCK_W + SETS_W;
    localparam int BLOCK_BYTES  = 32;
    // The six tests need under a hundred cycles, so this leaves a wide margin
    localparam int WATCHDOG_CYCLES = 2000;

    logic                        clk;
    logic                        rst_n_i;
    logic                        stall_i;
    logic                        squash_i;
    logic [bp_pkg::VADDR_W-1:0]  squash_target_i;
    logic                        update_i;
    bp_pkg::update_t             update_info_i;
    logic [bp_pkg::VADDR_W-1:0]  ind_target_i;
    logic                        pred_valid_o;
    bp_pkg::pred_result_t        pred_o;
    logic                        redirect_o;
    logic                        last_stage_o;
    bp_pkg::pred_result_t        last_pred_o;

    logic [31:0] lcg_state;
    int          error_count;
    int          check_count;

    always #(CLK_PERIOD / 2) clk = ~clk;

    fetch_predictor #(
        .BTB_SETS_W (SETS_W),
        .TAG_W      (TAG_BITS)
    ) UUT (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .stall_i         (stall_i),
        .squash_i        (squash_i),
        .squash_target_i (squash_target_i),
        .update_i        (update_i),
        .update_info_i   (update_info_i),
        .ind_target_i    (ind_target_i),
        .pred_valid_o    (pred_valid_o),
        .pred_o          (pred_o),
        .redirect_o      (redirect_o),
        .last_stage_o    (last_stage_o),
        .last_pred_o     (last_pred_o)
    );

    `include "tb_fetch_predictor_tasks.svh"

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        clk             = 1'b0;
        rst_n_i         = 1'b0;
        stall_i         = 1'b0;
        squash_i        = 1'b0;
        squash_target_i = '0;
        update_i        = 1'b0;
        update_info_i   = '0;
        ind_target_i    = '0;
        lcg_state       = 32'd66884;
        error_count     = 0;
        check_count     = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n_i = 1'b1;

        fall_through_after_reset();
        cond_branch_redirect();
        target_state_wrap();
        indirect_tail_target();
        squash_over_redirect();
        stall_holds_pc();

        $display("Summary: 6 tests, %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+verif
common/bp_pkg.sv
btb/btb_table.sv
verilog/dir_counter_table.sv
verilog/pred_result_gen.sv
verilog/fetch_predictor.sv
verif/tb_fetch_predictor.sv
